// ==== design/rv32_types.sv ====
package rv32_types;

    typedef logic [31:0] rv32_word;
    typedef logic [31:0] rv_instr_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_MADD   = 7'b1000011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_FMADD
    } alu_op_e;

    // Where execute takes an operand from
    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC,
        BYPASS_MEM
    } bypass_t;

    typedef struct packed {
        rv_opcode_e    opcode;
        alu_op_e       alu_op;
        reg_addr_t     rs1;
        reg_addr_t     rs2;
        reg_addr_t     rs3;
        reg_addr_t     rd;
        rv32_word      imm;
        // Bit i set when source i+1 is read
        logic [2:0]    use_rs;
        logic          writes_rd;
        logic          is_load;
        logic          is_store;
        logic          is_branch;
        logic          is_jump;
        bypass_t [2:0] bypass_rs;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word pc;
        logic     generate_nop;
    } fetch_decode_buffer_t;

    typedef struct packed {
        rv32_word       pc;
        rv_instr_t      instr;
        rv32_word       reg1;
        rv32_word       reg2;
        rv32_word       reg3;
        decoded_instr_t decoded_instr;
    } decode_exec_buffer_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      writes_rd;
        logic      is_load;
    } exec_mem_buffer_t;

    // addi x0, x0, 0
    localparam rv_instr_t RV_NOP = 32'h0000_0013;

    // A bubble reads and writes nothing
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl = '0;
        ctrl.opcode = OPC_OP_IMM;
        ctrl.alu_op = ALU_ADD;
        ctrl.bypass_rs = {BYPASS_NONE, BYPASS_NONE, BYPASS_NONE};
        return ctrl;
    endfunction

endpackage

// ==== design/rv32_decoder.sv ====
`timescale 1ns/1ns

module rv32_decoder (
    input  rv32_types::rv_instr_t      instr,
    output rv32_types::decoded_instr_t decoded_instr,
    output logic [2:0]                 use_rs
);
    import rv32_types::*;

    logic [2:0] use_bits;
    logic       has_rd;
    logic [2:0] funct3;
    rv32_word   imm_i;
    rv32_word   imm_s;
    rv32_word   imm_b;
    rv32_word   imm_u;
    rv32_word   imm_j;

    // Shared by OP and OP_IMM, alt selects SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3 = instr[14:12];

    // Sign-extended immediates of each format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded_instr = create_nop_ctrl();
        use_bits = 3'b000;
        has_rd = 1'b0;

        case (instr[6:0])
            OPC_LUI: begin
                decoded_instr.opcode = OPC_LUI;
                decoded_instr.alu_op = ALU_PASS_B;
                decoded_instr.imm = imm_u;
                has_rd = 1'b1;
            end
            OPC_AUIPC: begin
                decoded_instr.opcode = OPC_AUIPC;
                decoded_instr.imm = imm_u;
                has_rd = 1'b1;
            end
            OPC_JAL: begin
                decoded_instr.opcode = OPC_JAL;
                decoded_instr.imm = imm_j;
                decoded_instr.is_jump = 1'b1;
                has_rd = 1'b1;
            end
            OPC_JALR: begin
                decoded_instr.opcode = OPC_JALR;
                decoded_instr.imm = imm_i;
                decoded_instr.is_jump = 1'b1;
                use_bits = 3'b001;
                has_rd = 1'b1;
            end
            OPC_BRANCH: begin
                decoded_instr.opcode = OPC_BRANCH;
                // beq/bne compare by subtraction, the rest by set-less-than
                case (funct3[2:1])
                    2'b10:   decoded_instr.alu_op = ALU_SLT;
                    2'b11:   decoded_instr.alu_op = ALU_SLTU;
                    default: decoded_instr.alu_op = ALU_SUB;
                endcase
                decoded_instr.imm = imm_b;
                decoded_instr.is_branch = 1'b1;
                use_bits = 3'b011;
            end
            OPC_LOAD: begin
                decoded_instr.opcode = OPC_LOAD;
                decoded_instr.imm = imm_i;
                decoded_instr.is_load = 1'b1;
                use_bits = 3'b001;
                has_rd = 1'b1;
            end
            OPC_STORE: begin
                decoded_instr.opcode = OPC_STORE;
                decoded_instr.imm = imm_s;
                decoded_instr.is_store = 1'b1;
                use_bits = 3'b011;
            end
            OPC_OP_IMM: begin
                decoded_instr.alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && instr[30]);
                decoded_instr.imm = imm_i;
                use_bits = 3'b001;
                has_rd = 1'b1;
            end
            OPC_OP: begin
                decoded_instr.opcode = OPC_OP;
                decoded_instr.alu_op = alu_from_funct3(funct3, instr[30]);
                use_bits = 3'b011;
                has_rd = 1'b1;
            end
            OPC_MADD: begin
                // R4 format, rs3 sits in bits [31:27] and there is no immediate
                decoded_instr.opcode = OPC_MADD;
                decoded_instr.alu_op = ALU_FMADD;
                use_bits = 3'b111;
                has_rd = 1'b1;
            end
            OPC_SYSTEM: begin
                decoded_instr.opcode = OPC_SYSTEM;
                decoded_instr.imm = imm_i;
            end
            default: ;
        endcase

        // Fields a format does not use are zero
        decoded_instr.rs1 = use_bits[0] ? instr[19:15] : '0;
        decoded_instr.rs2 = use_bits[1] ? instr[24:20] : '0;
        decoded_instr.rs3 = use_bits[2] ? instr[31:27] : '0;
        decoded_instr.rd = has_rd ? instr[11:7] : '0;
        // A result for x0 is dropped, so it never counts as a write
        decoded_instr.writes_rd = has_rd && (instr[11:7] != 5'd0);
        decoded_instr.use_rs = use_bits;
        use_rs = use_bits;
    end

endmodule

// ==== design/rv32_hazard_detection_unit.sv ====
`timescale 1ns/1ns

module rv32_hazard_detection_unit (
    input  logic [2:0]                      use_rs,
    input  rv32_types::rv_instr_t           current_instr,
    input  rv32_types::decode_exec_buffer_t decode_exec_buff,
    input  rv32_types::exec_mem_buffer_t    exec_mem_buff,
    output logic                            stall,
    output rv32_types::bypass_t [2:0]       bypass_rs
);
    import rv32_types::*;

    reg_addr_t [2:0] src;
    logic [2:0]      src_live;
    logic [2:0]      hit_exec;
    logic [2:0]      hit_mem;
    logic [2:0]      load_use;
    reg_addr_t       exec_rd;
    logic            exec_writes;
    logic            exec_is_load;

    // Source indices at their fixed positions, rs3 from the R4 format
    assign src[0] = current_instr[19:15];
    assign src[1] = current_instr[24:20];
    assign src[2] = current_instr[31:27];

    // Instruction that sits in execute right now
    assign exec_rd = decode_exec_buff.decoded_instr.rd;
    assign exec_writes = decode_exec_buff.decoded_instr.writes_rd;
    assign exec_is_load = decode_exec_buff.decoded_instr.is_load;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            src_live[i] = use_rs[i] && (src[i] != 5'd0);
            hit_exec[i] = src_live[i] && exec_writes && (src[i] == exec_rd);
            hit_mem[i] = src_live[i] && exec_mem_buff.writes_rd && (src[i] == exec_mem_buff.rd);

            // Nearest producer wins
            if (hit_exec[i]) begin
                bypass_rs[i] = BYPASS_EXEC;
            end else if (hit_mem[i]) begin
                bypass_rs[i] = BYPASS_MEM;
            end else begin
                bypass_rs[i] = BYPASS_NONE;
            end

            // Load data only exists after the memory stage
            load_use[i] = hit_exec[i] && exec_is_load;
        end
    end

    assign stall = |load_use;

endmodule

// ==== design/rv32_regfile.sv ====
`timescale 1ns/1ns

module rv32_regfile #(
    parameter int reg_count = 32
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  rv32_types::reg_addr_t     rs1,
    input  rv32_types::reg_addr_t     rs2,
    input  rv32_types::reg_addr_t     rs3,
    output rv32_types::rv32_word [2:0] reg_data,
    input  logic                      wb_en,
    input  rv32_types::reg_addr_t     wb_addr,
    input  rv32_types::rv32_word      wb_data
);
    import rv32_types::*;

    rv32_word regs [reg_count];
    logic     wb_valid;

    // x0 and indices past the end are never written
    assign wb_valid = wb_en && (wb_addr != 5'd0) && (int'(wb_addr) < reg_count);

    // Write-through makes a value written this cycle visible at once
    function automatic rv32_word read_port(input reg_addr_t addr);
        if ((addr == 5'd0) || (int'(addr) >= reg_count)) begin
            return '0;
        end
        if (wb_valid && (wb_addr == addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        reg_data[0] = read_port(rs1);
        reg_data[1] = read_port(rs2);
        reg_data[2] = read_port(rs3);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

// ==== design/rv32_decode_stage.sv ====
`timescale 1ns/1ns

module rv32_decode_stage (
    input  logic                             clk,
    input  logic                             resetn,
    // Pipeline control
    input  logic                             set_nop,
    input  logic                             stop,
    input  rv32_types::rv32_word             set_nop_pc,
    input  rv32_types::fetch_decode_buffer_t fetch_decode_buff,
    output rv32_types::decode_exec_buffer_t  decode_exec_buff,
    output logic                             stall,
    // Instruction memory
    input  rv32_types::rv_instr_t            instr,
    // Register file
    input  rv32_types::rv32_word [2:0]       reg_data,
    output rv32_types::reg_addr_t [2:0]      rs_addr,
    // Later stage, used for bypassing
    input  rv32_types::exec_mem_buffer_t     exec_mem_buff
);
    import rv32_types::*;

    rv_instr_t           cur_instr;
    decoded_instr_t      decoder_out;
    logic [2:0]          use_rs;
    bypass_t [2:0]       bypass_rs;
    decode_exec_buffer_t stage_data;
    decode_exec_buffer_t next_buff;

    // Fetch bubbles become addi x0, x0, 0
    assign cur_instr = fetch_decode_buff.generate_nop ? RV_NOP : instr;

    assign rs_addr[0] = cur_instr[19:15];
    assign rs_addr[1] = cur_instr[24:20];
    assign rs_addr[2] = cur_instr[31:27];

    rv32_decoder decoder (
        .instr         (cur_instr),
        .decoded_instr (decoder_out),
        .use_rs        (use_rs)
    );

    rv32_hazard_detection_unit hazard_detection (
        .use_rs           (use_rs),
        .current_instr    (cur_instr),
        .decode_exec_buff (decode_exec_buff),
        .exec_mem_buff    (exec_mem_buff),
        .stall            (stall),
        .bypass_rs        (bypass_rs)
    );

    always_comb begin
        stage_data.pc = fetch_decode_buff.pc;
        stage_data.instr = cur_instr;
        stage_data.reg1 = reg_data[0];
        stage_data.reg2 = reg_data[1];
        stage_data.reg3 = reg_data[2];
        stage_data.decoded_instr = decoder_out;
        stage_data.decoded_instr.bypass_rs = bypass_rs;
    end

    // Load-use stall or a flush from later stages sends a bubble downstream
    always_comb begin
        next_buff = stage_data;
        if (stall || set_nop) begin
            next_buff.instr = RV_NOP;
            next_buff.decoded_instr = create_nop_ctrl();
            if (set_nop) begin
                next_buff.pc = set_nop_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_exec_buff.pc <= '0;
            decode_exec_buff.instr <= RV_NOP;
            decode_exec_buff.decoded_instr <= create_nop_ctrl();
        end else if (!stop) begin
            decode_exec_buff <= next_buff;
        end
    end

endmodule

// ==== design/rv32_decode_unit.sv ====
`timescale 1ns/1ns

module rv32_decode_unit #(
    // 32 for RV32I, 16 for RV32E
    parameter int reg_count = 32
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             set_nop,
    input  logic                             stop,
    input  rv32_types::rv32_word             set_nop_pc,
    input  rv32_types::fetch_decode_buffer_t fetch_decode_buff,
    input  rv32_types::rv_instr_t            instr,
    input  rv32_types::exec_mem_buffer_t     exec_mem_buff,
    // Writeback port
    input  logic                             wb_en,
    input  rv32_types::reg_addr_t            wb_addr,
    input  rv32_types::rv32_word             wb_data,
    output rv32_types::decode_exec_buffer_t  decode_exec_buff,
    output logic                             stall
);
    import rv32_types::*;

    reg_addr_t [2:0] rs_addr;
    rv32_word [2:0]  reg_data;

    rv32_regfile #(
        .reg_count (reg_count)
    ) regfile (
        .clk      (clk),
        .resetn   (resetn),
        .rs1      (rs_addr[0]),
        .rs2      (rs_addr[1]),
        .rs3      (rs_addr[2]),
        .reg_data (reg_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    rv32_decode_stage decode_stage (
        .clk               (clk),
        .resetn            (resetn),
        .set_nop           (set_nop),
        .stop              (stop),
        .set_nop_pc        (set_nop_pc),
        .fetch_decode_buff (fetch_decode_buff),
        .decode_exec_buff  (decode_exec_buff),
        .stall             (stall),
        .instr             (instr),
        .reg_data          (reg_data),
        .rs_addr           (rs_addr),
        .exec_mem_buff     (exec_mem_buff)
    );

endmodule

// ==== verification/rv32_decode_checker.sv ====
`timescale 1ns/1ns

module rv32_decode_checker (
    input  logic                            clk,
    input  logic                            resetn,
    // DUT outputs
    input  rv32_types::decode_exec_buffer_t decode_exec_buff,
    input  logic                            stall,
    // Values from the reference model
    input  rv32_types::decode_exec_buffer_t exp_buff,
    input  logic                            exp_stall,
    output int                              stall_errors,
    output int                              field_errors
);
    import rv32_types::*;

    initial begin
        stall_errors = 0;
        field_errors = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error t=%0t decode_exec_buff.%s expected %h actual %h",
                     $time, name, expected, actual);
            field_errors++;
        end
    endtask

    task automatic check_buffer();
        decoded_instr_t e;
        decoded_instr_t a;
        e = exp_buff.decoded_instr;
        a = decode_exec_buff.decoded_instr;
        compare_field("pc", exp_buff.pc, decode_exec_buff.pc);
        compare_field("instr", exp_buff.instr, decode_exec_buff.instr);
        // Operand words hold no value until the first decode after reset
        if (!$isunknown({exp_buff.reg1, exp_buff.reg2, exp_buff.reg3})) begin
            compare_field("reg1", exp_buff.reg1, decode_exec_buff.reg1);
            compare_field("reg2", exp_buff.reg2, decode_exec_buff.reg2);
            compare_field("reg3", exp_buff.reg3, decode_exec_buff.reg3);
        end
        compare_field("decoded_instr.opcode", e.opcode, a.opcode);
        compare_field("decoded_instr.alu_op", e.alu_op, a.alu_op);
        compare_field("decoded_instr.rs1", e.rs1, a.rs1);
        compare_field("decoded_instr.rs2", e.rs2, a.rs2);
        compare_field("decoded_instr.rs3", e.rs3, a.rs3);
        compare_field("decoded_instr.rd", e.rd, a.rd);
        compare_field("decoded_instr.imm", e.imm, a.imm);
        compare_field("decoded_instr.use_rs", e.use_rs, a.use_rs);
        compare_field("decoded_instr.writes_rd", e.writes_rd, a.writes_rd);
        compare_field("decoded_instr.is_load", e.is_load, a.is_load);
        compare_field("decoded_instr.is_store", e.is_store, a.is_store);
        compare_field("decoded_instr.is_branch", e.is_branch, a.is_branch);
        compare_field("decoded_instr.is_jump", e.is_jump, a.is_jump);
        for (int i = 0; i < 3; i++) begin
            compare_field($sformatf("decoded_instr.bypass_rs[%0d]", i),
                          e.bypass_rs[i], a.bypass_rs[i]);
        end
    endtask

    // Midway between edges, where inputs and the buffer are settled
    always @(negedge clk) begin
        if (resetn) begin
            if (stall !== exp_stall) begin
                $display("error t=%0t stall expected %b actual %b", $time, exp_stall, stall);
                stall_errors++;
            end
            check_buffer();
        end
    end

endmodule

// ==== verification/tb_rv32_decode_unit.sv ====
`timescale 1ns/1ns

module tb_rv32_decode_unit;
    import rv32_types::*;

    localparam int reg_count = 32;
    localparam int random_count = 400;
    // Roughly three times a full run including stalls and stops
    localparam int cycle_limit = 2000;

    // Opcodes of the random phase, the first entry is undefined
    localparam logic [11:0][6:0] opcode_pool = {
        7'b0001011, OPC_SYSTEM, OPC_MADD, OPC_OP, OPC_OP_IMM, OPC_STORE,
        OPC_LOAD, OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_AUIPC, OPC_LUI
    };
    // ALU operation by funct3 before funct7 is looked at
    localparam logic [7:0][3:0] alu_by_f3 = {
        ALU_AND, ALU_OR, ALU_SRL, ALU_XOR, ALU_SLTU, ALU_SLT, ALU_SLL, ALU_ADD
    };

    logic                 clk;
    logic                 resetn;
    logic                 set_nop;
    logic                 stop;
    rv32_word             set_nop_pc;
    fetch_decode_buffer_t fetch_decode_buff;
    rv_instr_t            instr;
    exec_mem_buffer_t     exec_mem_buff;
    logic                 wb_en;
    reg_addr_t            wb_addr;
    rv32_word             wb_data;
    decode_exec_buffer_t  decode_exec_buff;
    logic                 stall;

    // Reference model state
    rv32_word             regs_model [reg_count];
    decode_exec_buffer_t  exp_buff;
    logic                 exp_stall;
    logic                 hold_fetch;
    logic                 random_ctrl;
    rv32_word             fetch_pc;
    integer               seed = 1;
    int                   cycles = 0;
    int                   stall_errors;
    int                   field_errors;

    rv32_decode_unit #(
        .reg_count (reg_count)
    ) UUT (
        .clk               (clk),
        .resetn            (resetn),
        .set_nop           (set_nop),
        .stop              (stop),
        .set_nop_pc        (set_nop_pc),
        .fetch_decode_buff (fetch_decode_buff),
        .instr             (instr),
        .exec_mem_buff     (exec_mem_buff),
        .wb_en             (wb_en),
        .wb_addr           (wb_addr),
        .wb_data           (wb_data),
        .decode_exec_buff  (decode_exec_buff),
        .stall             (stall)
    );

    rv32_decode_checker decode_check (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .stall            (stall),
        .exp_buff         (exp_buff),
        .exp_stall        (exp_stall),
        .stall_errors     (stall_errors),
        .field_errors     (field_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Bubble control, nothing read and nothing written
    function automatic decoded_instr_t bubble_ctrl();
        decoded_instr_t c;
        c = '0;
        c.opcode = OPC_OP_IMM;
        c.alu_op = ALU_ADD;
        return c;
    endfunction

    function automatic decode_exec_buffer_t reset_buffer();
        decode_exec_buffer_t b;
        b = 'x;
        b.pc = '0;
        b.instr = RV_NOP;
        b.decoded_instr = bubble_ctrl();
        return b;
    endfunction

    function automatic decoded_instr_t expected_ctrl(input rv_instr_t ins);
        decoded_instr_t c;
        logic [2:0]     f3;
        logic           known;
        logic           rd_used;
        rv32_word       imm_i;
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        c = bubble_ctrl();
        known = 1'b1;
        rd_used = 1'b1;
        case (ins[6:0])
            OPC_LUI: begin
                c.alu_op = ALU_PASS_B;
                c.imm = {ins[31:12], 12'b0};
            end
            OPC_AUIPC: c.imm = {ins[31:12], 12'b0};
            OPC_JAL: begin
                c.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                c.is_jump = 1'b1;
            end
            OPC_JALR: begin
                c.imm = imm_i;
                c.is_jump = 1'b1;
                c.use_rs = 3'b001;
            end
            OPC_BRANCH: begin
                c.alu_op = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
                c.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                c.is_branch = 1'b1;
                c.use_rs = 3'b011;
                rd_used = 1'b0;
            end
            OPC_LOAD: begin
                c.imm = imm_i;
                c.is_load = 1'b1;
                c.use_rs = 3'b001;
            end
            OPC_STORE: begin
                c.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                c.is_store = 1'b1;
                c.use_rs = 3'b011;
                rd_used = 1'b0;
            end
            OPC_OP_IMM: begin
                c.alu_op = (ins[30] && f3 == 3'd5) ? ALU_SRA : alu_op_e'(alu_by_f3[f3]);
                c.imm = imm_i;
                c.use_rs = 3'b001;
            end
            OPC_OP: begin
                c.alu_op = alu_op_e'(alu_by_f3[f3]);
                if (ins[30] && f3 == 3'd0) c.alu_op = ALU_SUB;
                if (ins[30] && f3 == 3'd5) c.alu_op = ALU_SRA;
                c.use_rs = 3'b011;
            end
            OPC_MADD: begin
                c.alu_op = ALU_FMADD;
                c.use_rs = 3'b111;
            end
            OPC_SYSTEM: begin
                c.imm = imm_i;
                rd_used = 1'b0;
            end
            default: known = 1'b0;
        endcase
        if (known) c.opcode = rv_opcode_e'(ins[6:0]);
        c.rs1 = c.use_rs[0] ? ins[19:15] : 5'd0;
        c.rs2 = c.use_rs[1] ? ins[24:20] : 5'd0;
        c.rs3 = c.use_rs[2] ? ins[31:27] : 5'd0;
        c.rd = (known && rd_used) ? ins[11:7] : 5'd0;
        c.writes_rd = (c.rd != 5'd0);
        return c;
    endfunction

    // Register model read with write-through of the current writeback
    function automatic rv32_word read_model(input reg_addr_t addr);
        if (addr == 5'd0 || int'(addr) >= reg_count) return '0;
        if (wb_en && wb_addr == addr) return wb_data;
        return regs_model[addr];
    endfunction

    function automatic bypass_t expected_bypass(input logic used, input reg_addr_t src,
                                                input decode_exec_buffer_t prev,
                                                input exec_mem_buffer_t em);
        if (!used || src == 5'd0) return BYPASS_NONE;
        if (prev.decoded_instr.writes_rd && prev.decoded_instr.rd == src) return BYPASS_EXEC;
        if (em.writes_rd && em.rd == src) return BYPASS_MEM;
        return BYPASS_NONE;
    endfunction

    function automatic logic load_use(input decoded_instr_t c, input decode_exec_buffer_t prev);
        reg_addr_t rd;
        rd = prev.decoded_instr.rd;
        if (!(prev.decoded_instr.is_load && prev.decoded_instr.writes_rd)) return 1'b0;
        return (c.use_rs[0] && c.rs1 == rd) || (c.use_rs[1] && c.rs2 == rd) ||
               (c.use_rs[2] && c.rs3 == rd);
    endfunction

    function automatic decode_exec_buffer_t rv32_expected_buffer(
        input rv_instr_t ins, input rv32_word pc, input logic gen_nop, input logic flush,
        input rv32_word flush_pc, input decode_exec_buffer_t prev, input exec_mem_buffer_t em);
        decode_exec_buffer_t b;
        decoded_instr_t      c;
        rv_instr_t           cur;
        cur = gen_nop ? RV_NOP : ins;
        c = expected_ctrl(cur);
        b.pc = pc;
        b.instr = cur;
        b.reg1 = read_model(cur[19:15]);
        b.reg2 = read_model(cur[24:20]);
        b.reg3 = read_model(cur[31:27]);
        b.decoded_instr = c;
        b.decoded_instr.bypass_rs[0] = expected_bypass(c.use_rs[0], c.rs1, prev, em);
        b.decoded_instr.bypass_rs[1] = expected_bypass(c.use_rs[1], c.rs2, prev, em);
        b.decoded_instr.bypass_rs[2] = expected_bypass(c.use_rs[2], c.rs3, prev, em);
        if (flush || load_use(c, prev)) begin
            b.instr = RV_NOP;
            b.decoded_instr = bubble_ctrl();
            if (flush) b.pc = flush_pc;
        end
        return b;
    endfunction

    always_comb begin
        exp_stall = load_use(expected_ctrl(fetch_decode_buff.generate_nop ? RV_NOP : instr),
                             exp_buff);
    end

    function automatic rv_instr_t random_instr();
        rv_instr_t ins;
        int        sel;
        ins = $random(seed);
        sel = {$random(seed)} % 12;
        ins[6:0] = opcode_pool[sel];
        // Few registers, so hazards come up often
        ins[11:7] = {2'b00, 3'($random(seed))};
        ins[19:15] = {2'b00, 3'($random(seed))};
        ins[24:20] = {2'b00, 3'($random(seed))};
        if (ins[6:0] == OPC_MADD) ins[31:27] = {2'b00, 3'($random(seed))};
        return ins;
    endfunction

    // Model update from the inputs the DUT sees at this edge
    task automatic advance_model();
        decode_exec_buffer_t next;
        hold_fetch = exp_stall || stop;
        if (!resetn) begin
            exp_buff = reset_buffer();
            for (int i = 0; i < reg_count; i++) regs_model[i] = '0;
        end else begin
            next = rv32_expected_buffer(instr, fetch_decode_buff.pc,
                                        fetch_decode_buff.generate_nop, set_nop,
                                        set_nop_pc, exp_buff, exec_mem_buff);
            if (wb_en && wb_addr != 5'd0 && int'(wb_addr) < reg_count) begin
                regs_model[wb_addr] = wb_data;
            end
            if (!stop) exp_buff = next;
        end
    endtask

    // One clock, with execute, memory and writeback played by the testbench
    task automatic cycle();
        exec_mem_buffer_t em_next;
        @(posedge clk);
        em_next = exec_mem_buff;
        if (!stop) begin
            em_next.rd = exp_buff.decoded_instr.rd;
            em_next.writes_rd = exp_buff.decoded_instr.writes_rd;
            em_next.is_load = exp_buff.decoded_instr.is_load;
        end
        advance_model();
        exec_mem_buff <= em_next;
        wb_en <= exec_mem_buff.writes_rd;
        wb_addr <= exec_mem_buff.rd;
        wb_data <= $random(seed);
        stop <= random_ctrl && (($random(seed) & 7) == 0);
        set_nop <= random_ctrl && (($random(seed) & 15) == 0);
        set_nop_pc <= $random(seed);
    endtask

    // Fetch hands over the next word once the presented one is taken
    task automatic issue(input rv_instr_t ins, input logic gen_nop);
        do begin
            cycle();
        end while (hold_fetch);
        instr <= ins;
        fetch_decode_buff <= '{pc: fetch_pc, generate_nop: gen_nop};
        fetch_pc = fetch_pc + 32'd4;
    endtask

    task automatic drive_writeback(input reg_addr_t addr, input rv32_word data);
        wb_en <= 1'b1;
        wb_addr <= addr;
        wb_data <= data;
    endtask

    initial begin
        resetn = 1'b0;
        set_nop = 1'b0;
        stop = 1'b0;
        set_nop_pc = '0;
        fetch_decode_buff = '{pc: 32'd0, generate_nop: 1'b1};
        instr = RV_NOP;
        exec_mem_buff = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        exp_buff = reset_buffer();
        hold_fetch = 1'b0;
        random_ctrl = 1'b0;
        fetch_pc = '0;
        repeat (5) cycle();
        resetn <= 1'b1;

        // Fill the registers, x0 takes a write that must be dropped
        for (int i = 0; i < 32; i++) begin
            cycle();
            drive_writeback(5'(i), 32'h0101_0101 * i + 32'h10);
        end
        issue(32'h0000_03b3, 1'b0);
        issue(32'h0040_a283, 1'b0);
        issue(32'h0022_8333, 1'b0);
        issue(32'h0031_8433, 1'b0);
        drive_writeback(5'd3, 32'hcafe_f00d);
        issue(32'h1820_84c3, 1'b0);
        issue(32'h4094_0533, 1'b0);
        issue(32'hffff_ffff, 1'b0);
        issue(32'h0031_8433, 1'b1);
        issue(32'h0022_8333, 1'b0);
        set_nop <= 1'b1;
        set_nop_pc <= 32'h0000_8000;
        for (int i = 0; i < 3; i++) begin
            cycle();
            stop <= 1'b1;
        end

        random_ctrl = 1'b1;
        for (int n = 0; n < random_count; n++) begin
            issue(random_instr(), ($random(seed) & 15) == 0);
        end
        random_ctrl = 1'b0;
        repeat (3) cycle();
        @(posedge clk);

        $display("Errors: stall %0d, buffer fields %0d", stall_errors, field_errors);
        if (stall_errors + field_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rv32_decode_unit.f ====
design/rv32_types.sv
design/rv32_decoder.sv
design/rv32_hazard_detection_unit.sv
design/rv32_regfile.sv
design/rv32_decode_stage.sv
design/rv32_decode_unit.sv
verification/rv32_decode_checker.sv
verification/tb_rv32_decode_unit.sv

// ==== Bender.yml ====
package:
  name: rv32_decode_unit

sources:
  - files:
      - design/rv32_types.sv
      - design/rv32_decoder.sv
      - design/rv32_hazard_detection_unit.sv
      - design/rv32_regfile.sv
      - design/rv32_decode_stage.sv
      - design/rv32_decode_unit.sv
  - target: test
    files:
      - verification/rv32_decode_checker.sv
      - verification/tb_rv32_decode_unit.sv
